// ==== Makefile ====
# Verilator build and run of the vector ALU unit testbench

VERILATOR  ?= verilator
TOP        ?= valu_tb
FILELIST   ?= valu_lite.f
OBJ_DIR    ?= obj_dir
BUILD_JOBS ?= 4
VFLAGS     ?= --timing --assert

SRCS := $(wildcard source/*.sv verification/*.sv include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/valu_defines.svh ====
/*
  Shared size constants of the vector ALU unit.
  Included by the package, the RTL and the testbench.
*/
`ifndef VALU_DEFINES_SVH
`define VALU_DEFINES_SVH

// Datapath word width in bits
`define VALU_ELEN 64

// Instruction queue entries
`define VALU_INSN_DEPTH 4

// Result queue entries
`define VALU_RESULT_DEPTH 2

// Instruction ids, also the width of the done vector
`define VALU_NR_INSN 8

// Element count bits, up to 64 elements
`define VALU_VL_WIDTH 7

// Vector register number bits
`define VALU_VREG_WIDTH 5

// Data words per vector register
`define VALU_WORDS_PER_VREG 8

// Result word address bits
`define VALU_ADDR_WIDTH 8

`endif

// ==== source/valu_insn_queue.sv ====
/*
  Decode stage of the vector ALU unit.
  Holds accepted instructions in a ring, walks them through the issue phase
  (operand handshake and result push) and the commit phase (granted words),
  and pulses the done bit of each instruction after its last grant.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_insn_queue (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  // Operation port
  input  wire logic                         op_valid_i,
  input  valu_pkg::insn_id_t                op_id_i,
  input  valu_pkg::alu_op_e                 op_i,
  input  valu_pkg::vew_e                    vew_i,
  input  valu_pkg::vreg_t                   vd_i,
  input  valu_pkg::vl_t                     vl_i,
  input  wire logic                         use_scalar_i,
  input  valu_pkg::elen_t                   scalar_i,
  output logic                              ready_o,
  // Operand handshake
  input  wire logic [1:0]                   operand_valid_i,
  output logic      [1:0]                   operand_ready_o,
  // Instruction in issue, toward the ALU
  output valu_pkg::alu_op_e                 issue_op_o,
  output valu_pkg::vew_e                    issue_vew_o,
  output logic                              issue_use_scalar_o,
  output valu_pkg::elen_t                   issue_scalar_o,
  // Result queue side
  input  wire logic                         full_i,
  input  wire logic                         result_gnt_i,
  output logic                              push_o,
  output valu_pkg::insn_id_t                push_id_o,
  output valu_pkg::waddr_t                  push_addr_o,
  output logic      [`VALU_NR_INSN-1:0]     insn_done_o
);

  localparam int unsigned PNT_W = $clog2(`VALU_INSN_DEPTH);

  typedef logic [PNT_W-1:0] pnt_t;
  typedef logic [PNT_W:0]   cnt_t;

  // Ring pointer increment with wrap
  function automatic pnt_t next_pnt(input pnt_t p);
    if (p == pnt_t'(`VALU_INSN_DEPTH - 1)) begin
      return '0;
    end
    return p + pnt_t'(1);
  endfunction

  // Remaining elements after one word, stops at zero
  function automatic valu_pkg::vl_t rem_after_word(input valu_pkg::vl_t rem,
                                                   input valu_pkg::vew_e vew);
    valu_pkg::vl_t epw;
    // 8, 4, 2 or 1 elements per 64-bit word
    epw = valu_pkg::vl_t'((`VALU_ELEN / 8) >> vew);
    return (rem <= epw) ? '0 : rem - epw;
  endfunction

  // Instruction storage, payload only
  valu_pkg::valu_insn_t insn_q [`VALU_INSN_DEPTH];
  valu_pkg::valu_insn_t new_insn;

  pnt_t accept_pnt_d, accept_pnt_q;
  pnt_t issue_pnt_d, issue_pnt_q;
  pnt_t commit_pnt_d, commit_pnt_q;
  // Instructions waiting for issue, and for commit
  cnt_t issue_cnt_d, issue_cnt_q;
  cnt_t commit_cnt_d, commit_cnt_q;
  // Remaining elements of the instruction in each phase
  valu_pkg::vl_t issue_rem_d, issue_rem_q;
  valu_pkg::vl_t commit_rem_d, commit_rem_q;
  // Word index within the issuing instruction
  valu_pkg::waddr_t word_idx_d, word_idx_q;

  valu_pkg::valu_insn_t issue_insn, commit_insn;
  logic accept, fire;

  assign issue_insn  = insn_q[issue_pnt_q];
  assign commit_insn = insn_q[commit_pnt_q];

  // Full only while four instructions are between accept and commit
  assign ready_o = (commit_cnt_q != cnt_t'(`VALU_INSN_DEPTH));
  assign accept  = op_valid_i && ready_o;

  // Issue needs both operands and room in the result queue
  assign fire            = (issue_cnt_q != '0) && !full_i && (&operand_valid_i);
  assign operand_ready_o = {2{fire}};
  assign push_o          = fire;

  assign issue_op_o         = issue_insn.op;
  assign issue_vew_o        = issue_insn.vew;
  assign issue_use_scalar_o = issue_insn.use_scalar;
  assign issue_scalar_o     = issue_insn.scalar;
  assign push_id_o          = issue_insn.id;
  // Flat word address, wraps at 256
  assign push_addr_o = valu_pkg::waddr_t'(issue_insn.vd) *
                       valu_pkg::waddr_t'(`VALU_WORDS_PER_VREG) + word_idx_q;

  assign new_insn = '{
    id:         op_id_i,
    op:         op_i,
    vew:        vew_i,
    vd:         vd_i,
    vl:         vl_i,
    use_scalar: use_scalar_i,
    scalar:     scalar_i
  };

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    issue_rem_d  = issue_rem_q;
    commit_rem_d = commit_rem_q;
    word_idx_d   = word_idx_q;
    insn_done_o  = '0;

    // One word leaves the issue phase
    if (fire) begin
      issue_rem_d = rem_after_word(issue_rem_q, issue_insn.vew);
      word_idx_d  = word_idx_q + valu_pkg::waddr_t'(1);
      if (issue_rem_d == '0) begin
        issue_pnt_d = next_pnt(issue_pnt_q);
        issue_cnt_d = issue_cnt_q - cnt_t'(1);
        word_idx_d  = '0;
        // Load the next queued length if one is waiting
        if (issue_cnt_q > cnt_t'(1)) begin
          issue_rem_d = insn_q[issue_pnt_d].vl;
        end
      end
    end

    // Granted words always belong to the oldest instruction
    if (result_gnt_i && (commit_cnt_q != '0)) begin
      commit_rem_d = rem_after_word(commit_rem_q, commit_insn.vew);
      if (commit_rem_d == '0) begin
        insn_done_o[commit_insn.id] = 1'b1;
        commit_pnt_d = next_pnt(commit_pnt_q);
        commit_cnt_d = commit_cnt_q - cnt_t'(1);
        if (commit_cnt_q > cnt_t'(1)) begin
          commit_rem_d = insn_q[commit_pnt_d].vl;
        end
      end
    end

    // New instruction, counters start from its length if the phase is idle
    if (accept) begin
      if (issue_cnt_d == '0) begin
        issue_rem_d = vl_i;
      end
      if (commit_cnt_d == '0) begin
        commit_rem_d = vl_i;
      end
      accept_pnt_d = next_pnt(accept_pnt_q);
      issue_cnt_d  = issue_cnt_d + cnt_t'(1);
      commit_cnt_d = commit_cnt_d + cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= new_insn;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
      word_idx_q   <= '0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
      word_idx_q   <= word_idx_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/valu_pkg.sv ====
/*
  Types shared by the vector ALU unit: data words, operation and width
  encodings, instruction and result queue entries.
  Referenced by scoped names from the RTL and the testbench.
*/
`default_nettype none

`include "valu_defines.svh"

package valu_pkg;

  // One datapath word
  typedef logic [`VALU_ELEN-1:0] elen_t;

  // ALU operations
  typedef enum logic [3:0] {
    VAND,
    VOR,
    VXOR,
    VADD,
    VSUB,
    VRSUB,
    VMIN,
    VMINU,
    VMAX,
    VMAXU
  } alu_op_e;

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef logic [$clog2(`VALU_NR_INSN)-1:0] insn_id_t;
  typedef logic [`VALU_VL_WIDTH-1:0]        vl_t;
  typedef logic [`VALU_VREG_WIDTH-1:0]      vreg_t;
  typedef logic [`VALU_ADDR_WIDTH-1:0]      waddr_t;

  // Instruction as held in the instruction queue
  typedef struct packed {
    insn_id_t id;
    alu_op_e  op;
    vew_e     vew;
    vreg_t    vd;
    vl_t      vl;
    logic     use_scalar;
    elen_t    scalar;
  } valu_insn_t;

  // Result queue entry
  typedef struct packed {
    insn_id_t id;
    waddr_t   addr;
    elen_t    wdata;
  } result_t;

endpackage

`default_nettype wire

// ==== source/valu_result_queue.sv ====
/*
  Result stage of the vector ALU unit.
  Two-entry FIFO of result words; the oldest entry is held on the request
  outputs until granted. A push may share a cycle with a grant.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_result_queue (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  // Push side from decode and execute
  input  wire logic          push_i,
  input  valu_pkg::insn_id_t push_id_i,
  input  valu_pkg::waddr_t   push_addr_i,
  input  valu_pkg::elen_t    push_wdata_i,
  output logic               full_o,
  // Register file side
  output logic               req_o,
  output valu_pkg::insn_id_t id_o,
  output valu_pkg::waddr_t   addr_o,
  output valu_pkg::elen_t    wdata_o,
  input  wire logic          gnt_i
);

  localparam int unsigned PNT_W = $clog2(`VALU_RESULT_DEPTH);

  typedef logic [PNT_W-1:0] pnt_t;
  typedef logic [PNT_W:0]   cnt_t;

  function automatic pnt_t next_pnt(input pnt_t p);
    if (p == pnt_t'(`VALU_RESULT_DEPTH - 1)) begin
      return '0;
    end
    return p + pnt_t'(1);
  endfunction

  valu_pkg::result_t mem_q [`VALU_RESULT_DEPTH];
  valu_pkg::result_t head;

  pnt_t rd_pnt_q, wr_pnt_q;
  cnt_t cnt_q;
  logic pop;

  assign full_o = (cnt_q == cnt_t'(`VALU_RESULT_DEPTH));
  assign req_o  = (cnt_q != '0);
  // Grant only counts against a pending request
  assign pop    = gnt_i && req_o;

  // Oldest entry stays on the outputs until popped
  assign head    = mem_q[rd_pnt_q];
  assign id_o    = head.id;
  assign addr_o  = head.addr;
  assign wdata_o = head.wdata;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= '{id: push_id_i, addr: push_addr_i, wdata: push_wdata_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      // Simultaneous push and pop keep the level
      if (push_i && !pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (pop && !push_i) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/valu_simd_alu.sv ====
/*
  Execute stage of the vector ALU unit.
  Combinational SIMD ALU on one 64-bit word: bitwise, wrapping add/sub and
  min/max per element lane at 8, 16, 32 or 64 bits.
  Operand B may be replaced by the instruction's scalar.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_simd_alu (
  input  valu_pkg::elen_t   operand_a_i,
  input  valu_pkg::elen_t   operand_b_i,
  input  wire logic         use_scalar_i,
  input  valu_pkg::elen_t   scalar_i,
  input  valu_pkg::alu_op_e op_i,
  input  valu_pkg::vew_e    vew_i,
  output valu_pkg::elen_t   result_o
);

  // Same word seen as lanes of each width
  typedef union packed {
    logic [`VALU_ELEN/64-1:0][63:0] w64;
    logic [`VALU_ELEN/32-1:0][31:0] w32;
    logic [`VALU_ELEN/16-1:0][15:0] w16;
    logic [`VALU_ELEN/8-1:0][7:0]   w8;
  } lanes_t;

  // One lane of width w, operands zero extended into a full word
  function automatic valu_pkg::elen_t lane_calc(input valu_pkg::elen_t a,
                                                input valu_pkg::elen_t b,
                                                input int unsigned w,
                                                input valu_pkg::alu_op_e op);
    valu_pkg::elen_t mask;
    logic            sa, sb, lt;
    logic [`VALU_ELEN:0] xa, xb;
    // Shift by the full width gives zero, so w = 64 yields all ones
    mask = (valu_pkg::elen_t'(1) << w) - valu_pkg::elen_t'(1);
    // Sign bits only for the signed comparisons
    sa = (op inside {valu_pkg::VMIN, valu_pkg::VMAX}) && a[w-1];
    sb = (op inside {valu_pkg::VMIN, valu_pkg::VMAX}) && b[w-1];
    // Extend to 65 bits so one signed compare covers both flavours
    xa = {sa, sa ? (a | ~mask) : a};
    xb = {sb, sb ? (b | ~mask) : b};
    lt = $signed(xa) < $signed(xb);
    unique case (op)
      valu_pkg::VAND:  return a & b;
      valu_pkg::VOR:   return a | b;
      valu_pkg::VXOR:  return a ^ b;
      // Upper bits are dropped by the caller, so sums wrap per lane
      valu_pkg::VADD:  return a + b;
      valu_pkg::VSUB:  return a - b;
      valu_pkg::VRSUB: return b - a;
      valu_pkg::VMIN,
      valu_pkg::VMINU: return lt ? a : b;
      valu_pkg::VMAX,
      valu_pkg::VMAXU: return lt ? b : a;
      default:         return '0;
    endcase
  endfunction

  lanes_t opa, opb, res;

  assign opa      = operand_a_i;
  // Scalar operand takes the place of B
  assign opb      = use_scalar_i ? scalar_i : operand_b_i;
  assign result_o = res;

  always_comb begin
    res = '0;
    unique case (vew_i)
      valu_pkg::EW8: begin
        for (int l = 0; l < `VALU_ELEN / 8; l++) begin
          res.w8[l] = 8'(lane_calc(valu_pkg::elen_t'(opa.w8[l]),
                                   valu_pkg::elen_t'(opb.w8[l]), 8, op_i));
        end
      end
      valu_pkg::EW16: begin
        for (int l = 0; l < `VALU_ELEN / 16; l++) begin
          res.w16[l] = 16'(lane_calc(valu_pkg::elen_t'(opa.w16[l]),
                                     valu_pkg::elen_t'(opb.w16[l]), 16, op_i));
        end
      end
      valu_pkg::EW32: begin
        for (int l = 0; l < `VALU_ELEN / 32; l++) begin
          res.w32[l] = 32'(lane_calc(valu_pkg::elen_t'(opa.w32[l]),
                                     valu_pkg::elen_t'(opb.w32[l]), 32, op_i));
        end
      end
      default: begin
        // EW64, a single lane
        res.w64[0] = lane_calc(opa.w64[0], opb.w64[0], 64, op_i);
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/valu_top.sv ====
/*
  Top level of the vector ALU functional unit.
  Connects decode (instruction queue), execute (SIMD ALU) and result
  (result queue); a result word is requested one cycle after its operands.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Operation port
  input  wire logic                     op_valid_i,
  input  valu_pkg::insn_id_t            op_id_i,
  input  valu_pkg::alu_op_e             op_i,
  input  valu_pkg::vew_e                vew_i,
  input  valu_pkg::vreg_t               vd_i,
  input  valu_pkg::vl_t                 vl_i,
  input  wire logic                     use_scalar_i,
  input  valu_pkg::elen_t               scalar_i,
  output logic                          ready_o,
  // Operands
  input  valu_pkg::elen_t               operand_a_i,
  input  valu_pkg::elen_t               operand_b_i,
  input  wire logic [1:0]               operand_valid_i,
  output logic      [1:0]               operand_ready_o,
  // Register file write port
  output logic                          result_req_o,
  output valu_pkg::insn_id_t            result_id_o,
  output valu_pkg::waddr_t              result_addr_o,
  output valu_pkg::elen_t               result_wdata_o,
  input  wire logic                     result_gnt_i,
  // One pulse per finished instruction id
  output logic      [`VALU_NR_INSN-1:0] insn_done_o
);

  valu_pkg::alu_op_e  issue_op;
  valu_pkg::vew_e     issue_vew;
  logic               issue_use_scalar;
  valu_pkg::elen_t    issue_scalar;
  logic               push;
  valu_pkg::insn_id_t push_id;
  valu_pkg::waddr_t   push_addr;
  valu_pkg::elen_t    alu_result;
  logic               full;

  valu_insn_queue i_decode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .op_valid_i        (op_valid_i),
    .op_id_i           (op_id_i),
    .op_i              (op_i),
    .vew_i             (vew_i),
    .vd_i              (vd_i),
    .vl_i              (vl_i),
    .use_scalar_i      (use_scalar_i),
    .scalar_i          (scalar_i),
    .ready_o           (ready_o),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .issue_op_o        (issue_op),
    .issue_vew_o       (issue_vew),
    .issue_use_scalar_o(issue_use_scalar),
    .issue_scalar_o    (issue_scalar),
    .full_i            (full),
    .result_gnt_i      (result_gnt_i),
    .push_o            (push),
    .push_id_o         (push_id),
    .push_addr_o       (push_addr),
    .insn_done_o       (insn_done_o)
  );

  // Result is ready in the cycle the operands are consumed
  valu_simd_alu i_execute (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .use_scalar_i(issue_use_scalar),
    .scalar_i    (issue_scalar),
    .op_i        (issue_op),
    .vew_i       (issue_vew),
    .result_o    (alu_result)
  );

  valu_result_queue i_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (push),
    .push_id_i   (push_id),
    .push_addr_i (push_addr),
    .push_wdata_i(alu_result),
    .full_o      (full),
    .req_o       (result_req_o),
    .id_o        (result_id_o),
    .addr_o      (result_addr_o),
    .wdata_o     (result_wdata_o),
    .gnt_i       (result_gnt_i)
  );

endmodule

`default_nettype wire

// ==== valu_lite.f ====
+incdir+include
source/valu_pkg.sv
source/valu_insn_queue.sv
source/valu_simd_alu.sv
source/valu_result_queue.sv
source/valu_top.sv
verification/valu_assert.sv
verification/valu_tb.sv

// ==== verification/valu_assert.sv ====
/*
  Concurrent assertions on the vector ALU top level.
  Bound to every valu_top instance; checks the result handshake,
  the operand handshake and the operation length.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_assert (
  input wire logic               clk_i,
  input wire logic               rst_ni,
  input wire logic               op_valid_i,
  input wire logic               ready_o,
  input valu_pkg::vl_t           vl_i,
  input wire logic [1:0]         operand_valid_i,
  input wire logic [1:0]         operand_ready_o,
  input wire logic               result_req_o,
  input wire logic               result_gnt_i,
  input valu_pkg::insn_id_t      result_id_o,
  input valu_pkg::waddr_t        result_addr_o,
  input valu_pkg::elen_t         result_wdata_o
);

  // Grant is only legal against a pending request
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o)
    else $error("result grant without request");

  // Waiting entry keeps its fields until granted
  req_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_o && !result_gnt_i) |=> (result_req_o && $stable(result_id_o) &&
      $stable(result_addr_o) && $stable(result_wdata_o)))
    else $error("result request dropped or changed before grant");

  // Zero length instructions are not supported
  no_zero_length: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_valid_i && ready_o) |-> (vl_i != '0))
    else $error("operation accepted with zero length");

  // Operands are only taken when both are offered
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|operand_ready_o) |-> (&operand_valid_i))
    else $error("operand ready without both operand valids");

endmodule

bind valu_top valu_assert i_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .op_valid_i     (op_valid_i),
  .ready_o        (ready_o),
  .vl_i           (vl_i),
  .operand_valid_i(operand_valid_i),
  .operand_ready_o(operand_ready_o),
  .result_req_o   (result_req_o),
  .result_gnt_i   (result_gnt_i),
  .result_id_o    (result_id_o),
  .result_addr_o  (result_addr_o),
  .result_wdata_o (result_wdata_o)
);

`default_nettype wire

// ==== verification/valu_tb.sv ====
/*
  Directed testbench of the vector ALU unit.
  Each test task stages operand words and sends instructions; background
  processes feed operands, drive the grant and check every result word and
  done pulse against a reference model. Ends with $finish or $fatal.
*/
`timescale 1ns/1ps
`default_nettype none

`include "valu_defines.svh"

module valu_tb;

  localparam int unsigned CLK_PERIOD_NS   = 4;
  localparam int unsigned RESET_CYCLES    = 3;
  // Words issued over all tests, and a generous bound per word
  localparam int unsigned TEST_WORDS      = 6 + 12 + 16 + 5 + 5;
  localparam int unsigned CYCLES_PER_WORD = 20;
  localparam int unsigned WATCHDOG_NS =
    (TEST_WORDS * CYCLES_PER_WORD + RESET_CYCLES) * CLK_PERIOD_NS;

  // One expected result word with the operands that produce it
  typedef struct {
    valu_pkg::elen_t    a;
    valu_pkg::elen_t    b;
    valu_pkg::elen_t    data;
    valu_pkg::insn_id_t id;
    valu_pkg::waddr_t   addr;
  } word_t;

  // Accepted instruction awaiting its done pulse
  typedef struct {
    valu_pkg::insn_id_t id;
    int                 words;
  } insn_rec_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       op_valid_i;
  valu_pkg::insn_id_t         op_id_i;
  valu_pkg::alu_op_e          op_i;
  valu_pkg::vew_e             vew_i;
  valu_pkg::vreg_t            vd_i;
  valu_pkg::vl_t              vl_i;
  logic                       use_scalar_i;
  valu_pkg::elen_t            scalar_i;
  logic                       ready_o;
  valu_pkg::elen_t            operand_a_i;
  valu_pkg::elen_t            operand_b_i;
  logic [1:0]                 operand_valid_i;
  logic [1:0]                 operand_ready_o;
  logic                       result_req_o;
  valu_pkg::insn_id_t         result_id_o;
  valu_pkg::waddr_t           result_addr_o;
  valu_pkg::elen_t            result_wdata_o;
  logic                       result_gnt_i;
  logic [`VALU_NR_INSN-1:0]   insn_done_o;

  integer             seed = 32'ha22f_c3c9;
  int                 granted = 0;
  logic               gnt_en = 1'b1;
  logic               rsp_due = 1'b0;
  valu_pkg::insn_id_t next_id = '0;

  // Staged operands, words waiting for the operand port, words in flight
  valu_pkg::elen_t stage_a[$];
  valu_pkg::elen_t stage_b[$];
  word_t           word_q[$];
  word_t           sb_q[$];
  insn_rec_t       done_q[$];

  valu_top uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_valid_i     (op_valid_i),
    .op_id_i        (op_id_i),
    .op_i           (op_i),
    .vew_i          (vew_i),
    .vd_i           (vd_i),
    .vl_i           (vl_i),
    .use_scalar_i   (use_scalar_i),
    .scalar_i       (scalar_i),
    .ready_o        (ready_o),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_gnt_i   (result_gnt_i),
    .insn_done_o    (insn_done_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic valu_pkg::elen_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Words needed for vl elements, 8 >> vew elements per word
  function automatic int words_for(input valu_pkg::vl_t vl, input valu_pkg::vew_e vew);
    int epw;
    epw = 8 >> int'(vew);
    return (int'(vl) + epw - 1) / epw;
  endfunction

  // Reference result, lane by lane at the element width
  function automatic valu_pkg::elen_t model_word(input valu_pkg::alu_op_e op,
                                                 input valu_pkg::vew_e vew,
                                                 input valu_pkg::elen_t a,
                                                 input valu_pkg::elen_t b);
    int          w;
    logic [63:0] m, x, y, z, r;
    longint      sx, sy;
    w = 8 << int'(vew);
    m = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
    r = '0;
    for (int s = 0; s < 64; s += w) begin
      x  = (a >> s) & m;
      y  = (b >> s) & m;
      // Lane values as signed numbers
      sx = $signed(x << (64 - w)) >>> (64 - w);
      sy = $signed(y << (64 - w)) >>> (64 - w);
      case (op)
        valu_pkg::VAND:  z = x & y;
        valu_pkg::VOR:   z = x | y;
        valu_pkg::VXOR:  z = x ^ y;
        valu_pkg::VADD:  z = x + y;
        valu_pkg::VSUB:  z = x - y;
        valu_pkg::VRSUB: z = y - x;
        valu_pkg::VMIN:  z = (sx < sy) ? x : y;
        valu_pkg::VMAX:  z = (sx > sy) ? x : y;
        valu_pkg::VMINU: z = (x < y) ? x : y;
        valu_pkg::VMAXU: z = (x > y) ? x : y;
        default:         z = '0;
      endcase
      r = r | ((z & m) << s);
    end
    return r;
  endfunction

  task automatic stage_word(input valu_pkg::elen_t a, input valu_pkg::elen_t b);
    stage_a.push_back(a);
    stage_b.push_back(b);
  endtask

  // Offer one instruction, wait for accept, then release its words
  task automatic send_insn(input valu_pkg::alu_op_e op, input valu_pkg::vew_e vew,
                           input valu_pkg::vreg_t vd, input valu_pkg::vl_t vl,
                           input logic use_scalar, input valu_pkg::elen_t scalar);
    int                 n;
    word_t              w;
    insn_rec_t          rec;
    valu_pkg::insn_id_t id;
    n       = words_for(vl, vew);
    id      = next_id;
    next_id = next_id + 1'b1;
    if (stage_a.size() < n) begin
      report_error("fewer operand words staged than the instruction needs");
    end
    @(negedge clk_i);
    op_valid_i   = 1'b1;
    op_id_i      = id;
    op_i         = op;
    vew_i        = vew;
    vd_i         = vd;
    vl_i         = vl;
    use_scalar_i = use_scalar;
    scalar_i     = scalar;
    do @(posedge clk_i); while (!ready_o);
    for (int k = 0; k < n; k++) begin
      w.a    = stage_a.pop_front();
      w.b    = stage_b.pop_front();
      w.id   = id;
      // Flat address wraps at 256
      w.addr = valu_pkg::waddr_t'(int'(vd) * `VALU_WORDS_PER_VREG + k);
      w.data = model_word(op, vew, w.a, use_scalar ? scalar : w.b);
      word_q.push_back(w);
    end
    rec.id    = id;
    rec.words = n;
    done_q.push_back(rec);
    @(negedge clk_i);
    op_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge clk_i); while (word_q.size() != 0 || sb_q.size() != 0 || done_q.size() != 0);
    check("request when idle", 64'(result_req_o), 64'd0);
  endtask

  // Operands are presented as soon as their instruction is accepted
  always @(negedge clk_i) begin : operand_drive
    if (word_q.size() != 0) begin
      operand_a_i     = word_q[0].a;
      operand_b_i     = word_q[0].b;
      operand_valid_i = 2'b11;
    end else begin
      operand_valid_i = 2'b00;
    end
  end

  always @(negedge clk_i) begin : grant_drive
    result_gnt_i = gnt_en && result_req_o;
  end

  always @(posedge clk_i) begin : response_monitor
    word_t                    w;
    logic [`VALU_NR_INSN-1:0] exp_done;
    if (rst_ni) begin
      exp_done = '0;
      if (rsp_due) begin
        check("request one cycle after operands", 64'(result_req_o), 64'd1);
      end
      rsp_due = 1'b0;
      // Granted word, oldest first
      if (result_req_o && result_gnt_i) begin
        if (sb_q.size() == 0 || done_q.size() == 0) begin
          report_error("result granted while no word was expected");
        end
        w = sb_q.pop_front();
        check("result id", 64'(result_id_o), 64'(w.id));
        check("result address", 64'(result_addr_o), 64'(w.addr));
        check("result data", result_wdata_o, w.data);
        granted++;
        if (granted == done_q[0].words) begin
          exp_done[done_q[0].id] = 1'b1;
          void'(done_q.pop_front());
          granted = 0;
        end
      end
      // Consumed operands
      if (operand_ready_o == 2'b11) begin
        if (word_q.size() == 0) begin
          report_error("operands consumed while no word was pending");
        end
        sb_q.push_back(word_q.pop_front());
        rsp_due = 1'b1;
      end else if (operand_ready_o != 2'b00) begin
        report_error("operand ready bits did not rise together");
      end
      check("done vector", 64'(insn_done_o), 64'(exp_done));
    end
  end

  task automatic logic_ops_ew64();
    valu_pkg::alu_op_e ops[3];
    ops = '{valu_pkg::VAND, valu_pkg::VOR, valu_pkg::VXOR};
    for (int i = 0; i < 6; i++) begin
      stage_word(random_word(), random_word());
      send_insn(ops[i % 3], valu_pkg::EW64, valu_pkg::vreg_t'($random(seed)),
                valu_pkg::vl_t'(1), 1'b0, '0);
    end
    wait_idle();
  endtask

  // Carries and borrows cross every lane boundary
  task automatic add_sub_wrap();
    valu_pkg::alu_op_e ops[3];
    ops = '{valu_pkg::VADD, valu_pkg::VSUB, valu_pkg::VRSUB};
    for (int i = 0; i < 3; i++) begin
      for (int w = 0; w < 4; w++) begin
        stage_word(64'hFF7F_8001_FFFF_0080, 64'h01FF_80FF_0001_FF80);
        send_insn(ops[i], valu_pkg::vew_e'(w), valu_pkg::vreg_t'(i * 4 + w),
                  valu_pkg::vl_t'(8 >> w), 1'b0, '0);
      end
    end
    wait_idle();
  endtask

  // Top bits set in one operand or both, at every width
  task automatic min_max_signs();
    valu_pkg::alu_op_e ops[4];
    ops = '{valu_pkg::VMIN, valu_pkg::VMINU, valu_pkg::VMAX, valu_pkg::VMAXU};
    for (int i = 0; i < 4; i++) begin
      for (int w = 0; w < 4; w++) begin
        stage_word(64'h8001_7FFF_FF80_0180, 64'h7FFF_8001_80FF_FE7F);
        send_insn(ops[i], valu_pkg::vew_e'(w), valu_pkg::vreg_t'(16 + i * 4 + w),
                  valu_pkg::vl_t'(8 >> w), 1'b0, '0);
      end
    end
    wait_idle();
  endtask

  // 20 elements at EW16 give five words
  task automatic scalar_multi_word();
    for (int k = 0; k < 5; k++) begin
      stage_word(random_word(), random_word());
    end
    send_insn(valu_pkg::VADD, valu_pkg::EW16, valu_pkg::vreg_t'(5),
              valu_pkg::vl_t'(20), 1'b1, random_word());
    wait_idle();
  endtask

  task automatic back_pressure();
    @(posedge clk_i);
    gnt_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      stage_word(random_word(), random_word());
      send_insn(valu_pkg::VXOR, valu_pkg::EW64, valu_pkg::vreg_t'(i + 8),
                valu_pkg::vl_t'(1), 1'b0, '0);
    end
    check("ready after four accepts", 64'(ready_o), 64'd0);
    stage_word(random_word(), random_word());
    fork
      send_insn(valu_pkg::VSUB, valu_pkg::EW32, valu_pkg::vreg_t'(12),
                valu_pkg::vl_t'(2), 1'b0, '0);
      begin
        repeat (6) @(posedge clk_i);
        check("ready while stalled", 64'(ready_o), 64'd0);
        check("operand ready while stalled", 64'(operand_ready_o), 64'd0);
        check("words in result queue", 64'(sb_q.size()), 64'd2);
        check("words waiting for operands", 64'(word_q.size()), 64'd2);
        check("accepted instructions", 64'(done_q.size()), 64'd4);
        gnt_en = 1'b1;
      end
    join
    wait_idle();
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_error("watchdog expired before the tests finished");
  end

  initial begin : main
    rst_ni          = 1'b0;
    op_valid_i      = 1'b0;
    op_id_i         = '0;
    op_i            = valu_pkg::VAND;
    vew_i           = valu_pkg::EW8;
    vd_i            = '0;
    vl_i            = '0;
    use_scalar_i    = 1'b0;
    scalar_i        = '0;
    operand_a_i     = '0;
    operand_b_i     = '0;
    operand_valid_i = 2'b00;
    result_gnt_i    = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check("ready after reset", 64'(ready_o), 64'd1);
    check("request after reset", 64'(result_req_o), 64'd0);
    check("operand ready after reset", 64'(operand_ready_o), 64'd0);
    check("done after reset", 64'(insn_done_o), 64'd0);
    logic_ops_ew64();
    add_sub_wrap();
    min_max_signs();
    scalar_multi_word();
    back_pressure();
    repeat (2) @(negedge clk_i);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
